// File: alut_pkg.sv
//--------------------------------------
// address lookup table shared package
// register map, commands, table entry and
// request structs, hash function
//--------------------------------------

package alut_pkg;

   // table geometry
   localparam int ALUT_DEPTH = 8;
   localparam int ALUT_IDX_W = 3;

   // destination vector for frames to the switch itself
   localparam logic [4:0] D_PORT_HOST = 5'b1_0000;

   // apb word addresses
   typedef enum logic [6:0] {
      FRM_D_ADDR_L   = 7'h00,
      FRM_D_ADDR_U   = 7'h04,
      FRM_S_ADDR_L   = 7'h08,
      FRM_S_ADDR_U   = 7'h0c,
      S_PORT         = 7'h10,
      D_PORT         = 7'h14,
      MAC_ADDR_L     = 7'h18,
      MAC_ADDR_U     = 7'h1c,
      CUR_TIME       = 7'h20,
      BB_AGE         = 7'h24,
      DIV_CLK        = 7'h28,
      COMMAND        = 7'h2c,
      STATUS         = 7'h30,
      LST_INV_ADDR_L = 7'h34,
      LST_INV_ADDR_U = 7'h38,
      LST_INV_PORT   = 7'h3c
   } alut_reg_e;

   // command codes where 3 is ignored by both checkers
   typedef enum logic [1:0] {
      CMD_NONE        = 2'd0,
      CMD_CHECK_FRAME = 2'd1,
      CMD_INVAL_AGED  = 2'd2
   } alut_cmd_e;

   // frame under check
   typedef struct packed {
      logic [47:0] d_addr;
      logic [47:0] s_addr;
      logic [1:0]  s_port;
   } frame_req_t;

   // one table slot
   typedef struct packed {
      logic        valid;
      logic [47:0] addr;
      logic [1:0]  port;
      logic [31:0] stamp;   // time of learning
   } alut_entry_t;

   // last invalidated address and port
   typedef struct packed {
      logic [47:0] addr;
      logic [1:0]  port;
   } inval_rec_t;

   // table write request
   typedef struct packed {
      logic                  en;
      logic [ALUT_IDX_W-1:0] idx;
      alut_entry_t           entry;
   } mem_wr_t;

   // direct-mapped index from the low bits folded with bits 10:8
   function automatic logic [ALUT_IDX_W-1:0] alut_hash(input logic [47:0] addr);
      return addr[ALUT_IDX_W-1:0] ^ addr[8 +: ALUT_IDX_W];
   endfunction

endpackage

// File: alut_reg_bank.sv
//--------------------------------------
// apb register bank for the lookup table
// read mux, frame and config registers,
// command pulse, last invalidated record
//--------------------------------------
`timescale 1ns/1ps

module alut_reg_bank
(
   input  logic                  pclk20,
   input  logic                  n_p_reset20,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [6:0]            paddr,
   input  logic [31:0]           pwdata,
   input  logic [31:0]           curr_time,
   input  logic                  add_check_active,
   input  logic                  age_check_active,
   input  logic                  inval_in_prog,
   input  logic                  reused,
   input  logic [4:0]            d_port,
   input  alut_pkg::inval_rec_t  inv_nrm,
   input  alut_pkg::inval_rec_t  inv_cmd,
   output alut_pkg::frame_req_t  req,
   output logic [47:0]           mac_addr,
   output logic [31:0]           best_bfr_age,
   output logic [7:0]            div_clk,
   output alut_pkg::alut_cmd_e   command,
   output logic [31:0]           prdata,
   output logic                  clear_reused
);

   logic                 read_en;    // setup phase of a read
   logic                 write_en;   // access phase of a write
   logic                 active;     // either checker busy
   alut_pkg::inval_rec_t lst_inv;

   assign read_en  = psel & ~penable & ~pwrite;
   assign write_en = psel & penable & pwrite;
   assign active   = add_check_active | age_check_active;

   // status read while idle clears the sticky reuse flag
   assign clear_reused = read_en & (paddr == alut_pkg::STATUS) & ~active;

   //--------------------------------------
   // registered read mux
   //--------------------------------------
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         prdata <= 32'd0;
      else if (read_en)
      begin
         case (paddr)
            alut_pkg::FRM_D_ADDR_L   : prdata <= req.d_addr[31:0];
            alut_pkg::FRM_D_ADDR_U   : prdata <= {16'd0, req.d_addr[47:32]};
            alut_pkg::FRM_S_ADDR_L   : prdata <= req.s_addr[31:0];
            alut_pkg::FRM_S_ADDR_U   : prdata <= {16'd0, req.s_addr[47:32]};
            alut_pkg::S_PORT         : prdata <= {30'd0, req.s_port};
            alut_pkg::D_PORT         : prdata <= {27'd0, d_port};
            alut_pkg::MAC_ADDR_L     : prdata <= mac_addr[31:0];
            alut_pkg::MAC_ADDR_U     : prdata <= {16'd0, mac_addr[47:32]};
            alut_pkg::CUR_TIME       : prdata <= curr_time;
            alut_pkg::BB_AGE         : prdata <= best_bfr_age;
            alut_pkg::DIV_CLK        : prdata <= {24'd0, div_clk};
            alut_pkg::STATUS         : prdata <= {29'd0, reused, inval_in_prog, active};
            alut_pkg::LST_INV_ADDR_L : prdata <= lst_inv.addr[31:0];
            alut_pkg::LST_INV_ADDR_U : prdata <= {16'd0, lst_inv.addr[47:32]};
            alut_pkg::LST_INV_PORT   : prdata <= {30'd0, lst_inv.port};
            default                  : prdata <= 32'd0;   // unmapped, command
         endcase
      end
      else
         prdata <= 32'd0;   // only valid in access phase
   end

   //--------------------------------------
   // writable registers
   //--------------------------------------
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         req          <= '0;
         mac_addr     <= 48'd0;
         best_bfr_age <= 32'hffff_ffff;   // nothing ages out by default
         div_clk      <= 8'd0;
      end
      else if (write_en)
      begin
         case (paddr)
            alut_pkg::FRM_D_ADDR_L : req.d_addr[31:0]  <= pwdata;
            alut_pkg::FRM_D_ADDR_U : req.d_addr[47:32] <= pwdata[15:0];
            alut_pkg::FRM_S_ADDR_L : req.s_addr[31:0]  <= pwdata;
            alut_pkg::FRM_S_ADDR_U : req.s_addr[47:32] <= pwdata[15:0];
            alut_pkg::S_PORT       : req.s_port        <= pwdata[1:0];
            alut_pkg::MAC_ADDR_L   : mac_addr[31:0]    <= pwdata;
            alut_pkg::MAC_ADDR_U   : mac_addr[47:32]   <= pwdata[15:0];
            alut_pkg::BB_AGE       : best_bfr_age      <= pwdata;
            alut_pkg::DIV_CLK      : div_clk           <= pwdata[7:0];
            default                : ;   // read-only or unmapped
         endcase
      end
   end

   // command lasts a single cycle
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         command <= alut_pkg::CMD_NONE;
      else if (command != alut_pkg::CMD_NONE)
         command <= alut_pkg::CMD_NONE;   // self clear
      else if (write_en && paddr == alut_pkg::COMMAND)
         command <= alut_pkg::alut_cmd_e'(pwdata[1:0]);
   end

   //--------------------------------------
   // last invalidated address and port
   //--------------------------------------
   // normal operation overwrite wins over an aging scan
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         lst_inv <= '0;
      else if (reused)
         lst_inv <= inv_nrm;   // slot taken over by a new source
      else if (inval_in_prog)
         lst_inv <= inv_cmd;   // dropped by the age scan
   end

endmodule

// File: alut_timer.sv
//--------------------------------------
// time base for entry stamps
// prescaler and free running counter
//--------------------------------------
`timescale 1ns/1ps

module alut_timer
(
   input  logic        pclk20,
   input  logic        n_p_reset20,
   input  logic [7:0]  div_clk,
   output logic [31:0] curr_time
);

   logic [7:0] presc;   // counts 0 .. div_clk

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         presc     <= 8'd0;
         curr_time <= 32'd0;
      end
      else if (presc >= div_clk)   // also catches a smaller new divider
      begin
         presc     <= 8'd0;
         curr_time <= curr_time + 32'd1;   // one tick per div_clk+1 cycles
      end
      else
         presc <= presc + 8'd1;
   end

endmodule

// File: alut_addr_check.sv
//--------------------------------------
// address checker stage
// learns the source, looks up destination,
// builds the destination port vector
//--------------------------------------
`timescale 1ns/1ps

module alut_addr_check
(
   input  logic                                 pclk20,
   input  logic                                 n_p_reset20,
   input  alut_pkg::alut_cmd_e                  command,
   input  alut_pkg::frame_req_t                 req,
   input  logic [47:0]                          mac_addr,
   input  logic [31:0]                          curr_time,
   input  logic                                 clear_reused,
   input  alut_pkg::alut_entry_t                rd_s_data,
   input  alut_pkg::alut_entry_t                rd_d_data,
   output logic [alut_pkg::ALUT_IDX_W-1:0]      rd_s_idx,
   output logic [alut_pkg::ALUT_IDX_W-1:0]      rd_d_idx,
   output alut_pkg::mem_wr_t                    wr,
   output logic                                 add_check_active,
   output logic [4:0]                           d_port,
   output logic                                 reused,
   output alut_pkg::inval_rec_t                 inv_nrm
);

   typedef enum logic [1:0] {
      CK_IDLE,
      CK_READ,    // latch both table slots
      CK_WRITE    // learn source, resolve destination
   } ck_state_e;

   ck_state_e             state;
   alut_pkg::alut_entry_t s_ent;        // slot the source maps to
   alut_pkg::alut_entry_t d_ent;        // slot the destination maps to
   logic [4:0]            d_port_nxt;
   logic [4:0]            flood;
   logic                  bcast;
   logic                  reuse_hit;

   assign rd_s_idx = alut_pkg::alut_hash(req.s_addr);
   assign rd_d_idx = alut_pkg::alut_hash(req.d_addr);

   assign add_check_active = (state != CK_IDLE);

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
         state <= CK_IDLE;
      else
      begin
         case (state)
            CK_IDLE  : if (command == alut_pkg::CMD_CHECK_FRAME) state <= CK_READ;
            CK_READ  : state <= CK_WRITE;
            default  : state <= CK_IDLE;
         endcase
      end
   end

   // table slots latched in the read cycle
   always_ff @(posedge pclk20)
   begin
      if (state == CK_READ)
      begin
         s_ent <= rd_s_data;
         d_ent <= rd_d_data;
      end
   end

   // learned entry goes into the source slot
   always_comb
   begin
      wr             = '0;
      wr.en          = (state == CK_WRITE);
      wr.idx         = rd_s_idx;
      wr.entry.valid = 1'b1;
      wr.entry.addr  = req.s_addr;
      wr.entry.port  = req.s_port;
      wr.entry.stamp = curr_time;
   end

   //--------------------------------------
   // destination vector
   //--------------------------------------
   assign bcast = &req.d_addr;
   assign flood = 5'b0_1111 & ~(5'b0_0001 << req.s_port);   // all but source

   always_comb
   begin
      if (req.d_addr == mac_addr)
         d_port_nxt = alut_pkg::D_PORT_HOST;
      else if (!bcast && d_ent.valid && d_ent.addr == req.d_addr)
         d_port_nxt = 5'b0_0001 << d_ent.port;   // known station
      else
         d_port_nxt = flood;                     // miss or broadcast
   end

   // source slot held some other station
   assign reuse_hit = s_ent.valid && (s_ent.addr != req.s_addr);

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         d_port  <= 5'd0;
         reused  <= 1'b0;
         inv_nrm <= '0;
      end
      else if (state == CK_WRITE)
      begin
         d_port <= d_port_nxt;
         if (reuse_hit)
         begin
            reused       <= 1'b1;
            inv_nrm.addr <= s_ent.addr;
            inv_nrm.port <= s_ent.port;
         end
      end
      else if (clear_reused)
         reused <= 1'b0;   // sticky until status read
   end

endmodule

// File: alut_age_check.sv
//--------------------------------------
// age checker stage
// scans all slots, drops stale entries
//--------------------------------------
`timescale 1ns/1ps

module alut_age_check
(
   input  logic                                 pclk20,
   input  logic                                 n_p_reset20,
   input  alut_pkg::alut_cmd_e                  command,
   input  logic [31:0]                          best_bfr_age,
   input  logic [31:0]                          curr_time,
   input  alut_pkg::alut_entry_t                rd_data,
   output logic [alut_pkg::ALUT_IDX_W-1:0]      rd_idx,
   output alut_pkg::mem_wr_t                    wr,
   output logic                                 age_check_active,
   output logic                                 inval_in_prog,
   output alut_pkg::inval_rec_t                 inv_cmd
);

   typedef enum logic {
      AG_IDLE,
      AG_SCAN
   } ag_state_e;

   ag_state_e                       state;
   logic [alut_pkg::ALUT_IDX_W-1:0] idx;     // slot under test
   logic [31:0]                     age;     // wraps modulo 2^32
   logic                            drop;

   assign rd_idx           = idx;
   assign age_check_active = (state == AG_SCAN);

   assign age  = curr_time - rd_data.stamp;
   assign drop = (state == AG_SCAN) && rd_data.valid && (age > best_bfr_age);

   // clear valid, keep the rest of the slot
   always_comb
   begin
      wr             = '0;
      wr.en          = drop;
      wr.idx         = idx;
      wr.entry       = rd_data;
      wr.entry.valid = 1'b0;
   end

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         state <= AG_IDLE;
         idx   <= '0;
      end
      else if (state == AG_IDLE)
      begin
         idx <= '0;
         if (command == alut_pkg::CMD_INVAL_AGED)
            state <= AG_SCAN;
      end
      else
      begin
         idx <= idx + 1'b1;
         if (idx == alut_pkg::ALUT_IDX_W'(alut_pkg::ALUT_DEPTH - 1))
            state <= AG_IDLE;   // last slot done
      end
   end

   // in-progress trails the scan by a cycle so the
   // record of the final slot still gets captured
   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         inval_in_prog <= 1'b0;
         inv_cmd       <= '0;
      end
      else
      begin
         inval_in_prog <= (state == AG_SCAN);
         if (drop)
         begin
            inv_cmd.addr <= rd_data.addr;
            inv_cmd.port <= rd_data.port;
         end
      end
   end

endmodule

// File: alut_mem.sv
//--------------------------------------
// lookup table storage
// 8 slots, three reads, one write port
//--------------------------------------
`timescale 1ns/1ps

module alut_mem
(
   input  logic                                 pclk20,
   input  logic                                 n_p_reset20,
   input  logic [alut_pkg::ALUT_IDX_W-1:0]      ac_s_idx,
   input  logic [alut_pkg::ALUT_IDX_W-1:0]      ac_d_idx,
   input  logic [alut_pkg::ALUT_IDX_W-1:0]      ag_idx,
   input  alut_pkg::mem_wr_t                    ac_wr,
   input  alut_pkg::mem_wr_t                    ag_wr,
   output alut_pkg::alut_entry_t                ac_s_data,
   output alut_pkg::alut_entry_t                ac_d_data,
   output alut_pkg::alut_entry_t                ag_data
);

   alut_pkg::alut_entry_t tbl [alut_pkg::ALUT_DEPTH];

   // combinational reads
   assign ac_s_data = tbl[ac_s_idx];
   assign ac_d_data = tbl[ac_d_idx];
   assign ag_data   = tbl[ag_idx];

   always_ff @(posedge pclk20 or negedge n_p_reset20)
   begin
      if (!n_p_reset20)
      begin
         for (int i = 0; i < alut_pkg::ALUT_DEPTH; i++)
            tbl[i] <= '0;   // all slots invalid
      end
      else if (ac_wr.en)
         tbl[ac_wr.idx] <= ac_wr.entry;   // address checker first
      else if (ag_wr.en)
         tbl[ag_wr.idx] <= ag_wr.entry;
   end

endmodule

// File: alut_top.sv
//--------------------------------------
// address lookup table top level
// reg bank, timer, checkers, table
//--------------------------------------
`timescale 1ns/1ps

module alut_top
(
   input  logic        pclk20,
   input  logic        n_p_reset20,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   alut_pkg::frame_req_t            req;
   logic [47:0]                     mac_addr;
   logic [31:0]                     best_bfr_age;
   logic [7:0]                      div_clk;
   alut_pkg::alut_cmd_e             command;
   logic                            clear_reused;
   logic [31:0]                     curr_time;
   logic                            add_check_active;
   logic                            age_check_active;
   logic                            inval_in_prog;
   logic                            reused;
   logic [4:0]                      d_port;
   alut_pkg::inval_rec_t            inv_nrm;
   alut_pkg::inval_rec_t            inv_cmd;
   logic [alut_pkg::ALUT_IDX_W-1:0] ac_s_idx;
   logic [alut_pkg::ALUT_IDX_W-1:0] ac_d_idx;
   logic [alut_pkg::ALUT_IDX_W-1:0] ag_idx;
   alut_pkg::mem_wr_t               ac_wr;
   alut_pkg::mem_wr_t               ag_wr;
   alut_pkg::alut_entry_t           ac_s_data;
   alut_pkg::alut_entry_t           ac_d_data;
   alut_pkg::alut_entry_t           ag_data;

   alut_reg_bank alut_reg_bank_i (
      .pclk20, .n_p_reset20, .psel, .penable, .pwrite, .paddr, .pwdata,
      .curr_time, .add_check_active, .age_check_active, .inval_in_prog,
      .reused, .d_port, .inv_nrm, .inv_cmd, .req, .mac_addr,
      .best_bfr_age, .div_clk, .command, .prdata, .clear_reused
   );

   alut_timer alut_timer_i (.pclk20, .n_p_reset20, .div_clk, .curr_time);

   // learn and lookup
   alut_addr_check alut_addr_check_i (
      .pclk20, .n_p_reset20, .command, .req, .mac_addr, .curr_time,
      .clear_reused, .rd_s_data(ac_s_data), .rd_d_data(ac_d_data),
      .rd_s_idx(ac_s_idx), .rd_d_idx(ac_d_idx), .wr(ac_wr),
      .add_check_active, .d_port, .reused, .inv_nrm
   );

   // aging scan
   alut_age_check alut_age_check_i (
      .pclk20, .n_p_reset20, .command, .best_bfr_age, .curr_time,
      .rd_data(ag_data), .rd_idx(ag_idx), .wr(ag_wr),
      .age_check_active, .inval_in_prog, .inv_cmd
   );

   alut_mem alut_mem_i (
      .pclk20, .n_p_reset20, .ac_s_idx, .ac_d_idx, .ag_idx,
      .ac_wr, .ag_wr, .ac_s_data, .ac_d_data, .ag_data
   );

endmodule

// File: tb_alut.sv
//----------------------------------------
// testbench for the address lookup table
// apb driver, case file reader, read and
// delta checks, cycle limit watchdog
//----------------------------------------
`timescale 1ns/1ps

module tb_alut;

   logic        pclk20;
   logic        n_p_reset20;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   // parsed case file with one entry per operation
   byte         op_q[$];
   logic [6:0]  addr_q[$];
   logic [31:0] data_q[$];
   int          line_q[$];   // file line for messages

   int          checks;
   int          mismatches;
   int          other_errs;
   int          cycles;
   int          cycle_limit;   // 0 until the cases are loaded
   logic [31:0] mark;          // reference for delta reads

   alut_top alut_top_i (
      .pclk20, .n_p_reset20, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata
   );

   initial
   begin
      pclk20 = 1'b0;
      forever #4 pclk20 = ~pclk20;   // 8 ns period
   end

   //----------------------------------------
   // watchdog
   //----------------------------------------
   initial
   begin
      cycles = 0;
      wait (cycle_limit > 0);
      while (cycles < cycle_limit)
      begin
         @(posedge pclk20);
         cycles++;
      end
      $display("run stopped by the cycle limit after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // lines starting with # or empty are skipped
   task automatic load_cases();
      int          fd;
      int          n;
      int          line_no;
      string       line;
      logic [31:0] a_v;
      logic [31:0] d_v;
      fd = $fopen("alut_cases.txt", "r");
      if (fd == 0)
      begin
         other_errs++;
         $display("cannot open the case file alut_cases.txt");
         return;
      end
      line_no = 0;
      while ($fgets(line, fd) > 0)
      begin
         line_no++;
         if (line.len() < 2 || line.getc(0) == "#" || line.getc(0) == "\n")
            continue;
         n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a_v, d_v);
         if (n != 2)
         begin
            other_errs++;
            $display("case line %0d could not be parsed", line_no);
            continue;
         end
         op_q.push_back(line.getc(0));
         addr_q.push_back(a_v[6:0]);
         data_q.push_back(d_v);
         line_q.push_back(line_no);
      end
      $fclose(fd);
   endtask

   //----------------------------------------
   // apb transfers entered on a falling edge
   //----------------------------------------
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      psel    = 1'b1;   // setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk20);
      penable = 1'b1;   // access phase so the write lands on the next rise
      @(negedge pclk20);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk20);
      penable = 1'b1;
      data    = prdata;   // registered at the setup edge
      @(negedge pclk20);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // one idle cycle first so a fresh command has reached its checker
   task automatic poll_idle(input int line_no, input int limit);
      logic [31:0] st;
      int          waited;
      waited = 0;
      @(negedge pclk20);
      apb_read(alut_pkg::STATUS, st);
      waited += 2;
      while (st[0] && waited < limit)
      begin
         apb_read(alut_pkg::STATUS, st);
         waited += 2;
      end
      if (st[0])
      begin
         other_errs++;
         $display("case line %0d: checker still busy after %0d cycles", line_no, waited);
      end
   endtask

   task automatic run_case(input int i);
      logic [31:0] got;
      logic [31:0] delta;
      case (op_q[i])
         "w" : apb_write(addr_q[i], data_q[i]);
         "r" :
         begin
            apb_read(addr_q[i], got);
            checks++;
            assert (got === data_q[i])
            else
            begin
               mismatches++;
               $display("CHECK FAILED case line %0d read 0x%02h: expected 0x%08h actual 0x%08h",
                        line_q[i], addr_q[i], data_q[i], got);
            end
         end
         "d" : repeat (data_q[i]) @(negedge pclk20);
         "p" : poll_idle(line_q[i], int'(data_q[i]));
         "m" : apb_read(addr_q[i], mark);
         "t" :
         begin
            apb_read(addr_q[i], got);
            delta = got - mark;   // wraps like the counter
            checks++;
            assert (delta >= data_q[i] && delta <= data_q[i] + 32'd1)
            else
            begin
               mismatches++;
               $display("CHECK FAILED case line %0d delta 0x%02h: expected %0d..%0d actual %0d",
                        line_q[i], addr_q[i], data_q[i], data_q[i] + 32'd1, delta);
            end
         end
         default :
         begin
            other_errs++;
            $display("case line %0d has an unknown operation", line_q[i]);
         end
      endcase
   endtask

   //----------------------------------------
   // main sequence
   //----------------------------------------
   initial
   begin
      n_p_reset20 = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = 7'd0;
      pwdata      = 32'd0;
      checks      = 0;
      mismatches  = 0;
      other_errs  = 0;
      mark        = 32'd0;
      load_cases();
      if (op_q.size() == 0)
      begin
         other_errs++;
         $display("no operations found in the case file");
      end
      cycle_limit = 40 * op_q.size();   // starts the watchdog
      repeat (8) @(negedge pclk20);
      n_p_reset20 = 1'b1;
      foreach (op_q[i])
         run_case(i);
      $display("%0d checks, %0d mismatches, %0d other errors", checks, mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: alut_cases.txt
# op addr data, both hex: w write, r read and expect data, d wait data cycles,
# p poll status until idle within data cycles, m read as reference, t read and expect +data or +data+1
# reset values
r 24 ffffffff
r 30 00000000
r 34 00000000
r 38 00000000
r 3c 00000000
r 14 00000000
r 28 00000000
# write and read back, upper halves masked
w 18 0000beef
w 1c 1234abcd
r 18 0000beef
r 1c 0000abcd
w 04 ffffffff
r 04 0000ffff
w 10 00000006
r 10 00000002
# learn 0x103 from port 2 into slot 2, unknown destination floods
w 04 00000000
w 08 00000103
w 00 00000555
w 2c 00000001
d 00 00000004
r 14 0000000b
# source 0x204 port 0 in slot 6 looks up 0x103
w 08 00000204
w 10 00000000
w 00 00000103
w 2c 00000001
d 00 00000004
r 14 00000004
# destination is the switch mac, 0x204 moves to port 3
w 10 00000003
w 00 0000beef
w 04 0000abcd
w 2c 00000001
d 00 00000004
r 14 00000010
r 30 00000000
# 0x002 from port 1 takes slot 2 from 0x103
w 08 00000002
w 10 00000001
w 04 00000000
w 2c 00000001
d 00 00000004
r 30 00000004
r 30 00000000
r 34 00000103
r 38 00000000
r 3c 00000002
r 14 0000000d
# aging with reset best-before age keeps entries
w 2c 00000002
p 30 00000028
w 00 00000204
w 2c 00000001
d 00 00000004
r 14 00000008
# aging with zero best-before age drops slots 2 and 6, slot 6 last
w 24 00000000
r 24 00000000
d 00 00000008
w 2c 00000002
p 30 00000028
r 30 00000000
r 34 00000204
r 38 00000000
r 3c 00000003
w 2c 00000001
d 00 00000004
r 14 0000000d
# time base with divider 3, reads 20 cycles apart
w 28 00000003
r 28 00000003
d 00 00000004
m 20 00000000
d 00 00000012
t 20 00000004

// File: alut_top.f
alut_pkg.sv
alut_reg_bank.sv
alut_timer.sv
alut_addr_check.sv
alut_age_check.sv
alut_mem.sv
alut_top.sv
tb_alut.sv

// File: Makefile
# verilator build and run of the address lookup table testbench

TOP = tb_alut

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f alut_top.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
